// File: hdl/dnn_mem_pkg.sv
/* shared types for the read bridge; every beat is 8 bytes wide and a
   command of zero beats is illegal */
`default_nettype none

package dnn_mem_pkg;

	// byte address on the memory port
	typedef logic [31:0] addr_t;

	// one memory beat that is also the input buffer word
	typedef logic [63:0] data_t;

	// beats per read command where zero is illegal
	typedef logic [9:0] beats_t;

	// address stride between consecutive beats
	localparam int unsigned beat_bytes = 8;

	// sequencer states
	typedef enum logic [0:0] {
		seq_idle,  // waiting for a queued command
		seq_issue  // fracturing the active command into beats
	} seq_state_t;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
/* first-word-fall-through FIFO, head valid at dout while empty is low;
   push when full and pop when empty are ignored */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH     = 32,
	parameter int LOG_DEPTH = 4
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             push,
	input  wire logic [WIDTH-1:0] din,
	input  wire logic             pop,
	output logic      [WIDTH-1:0] dout,
	output logic                  full,
	output logic                  empty
);

	localparam int DEPTH = 1 << LOG_DEPTH;

	logic [WIDTH-1:0]     mem [DEPTH];  // storage words
	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	logic [LOG_DEPTH:0]   count;        // one extra bit to tell full from empty
	logic                 do_push;
	logic                 do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == (LOG_DEPTH+1)'(DEPTH));
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr]; // fall-through head

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/read_sequencer.sv
/* queues read commands and fractures each into single-beat requests;
   a command sent while the command queue is full is lost */
`timescale 1ns/100ps
`default_nettype none

module read_sequencer import dnn_mem_pkg::*; #(
	parameter int LOG_DEPTH = 4
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   rd_req,        // command strobe
	input  wire addr_t  rd_addr,
	input  wire beats_t rd_beats,
	input  wire logic   mem_req_grant,
	input  wire logic   tag_room,      // merge can track one more beat
	input  wire logic   merge_idle,    // nothing outstanding downstream
	output logic        rd_ready,
	output logic        mem_req_valid,
	output addr_t       mem_req_addr,
	output logic        beat_issue     // one pulse per queued beat
);

	localparam int CMD_W = $bits(addr_t) + $bits(beats_t);

	// command queue with {addr, beats} words
	logic [CMD_W-1:0] cmd_dout;
	logic             cmd_full;
	logic             cmd_empty;
	logic             cmd_pop;

	// request queue towards memory
	logic req_full;
	logic req_empty;

	seq_state_t state;
	addr_t      cur_addr;   // address of the next beat
	beats_t     beats_left; // beats still to queue including the current one

	sync_fifo #(.WIDTH(CMD_W), .LOG_DEPTH(LOG_DEPTH)) cmd_q (
		.clk   (clk),
		.rst   (rst),
		.push  (rd_req && !cmd_full), // no back-pressure on the command side
		.din   ({rd_addr, rd_beats}),
		.pop   (cmd_pop),
		.dout  (cmd_dout),
		.full  (cmd_full),
		.empty (cmd_empty)
	);

	sync_fifo #(.WIDTH($bits(addr_t)), .LOG_DEPTH(LOG_DEPTH)) req_q (
		.clk   (clk),
		.rst   (rst),
		.push  (beat_issue),
		.din   (cur_addr),
		.pop   (mem_req_valid && mem_req_grant), // leaves on valid and grant
		.dout  (mem_req_addr),
		.full  (req_full),
		.empty (req_empty)
	);

	assign mem_req_valid = !req_empty;

	// take the head command only when idle
	assign cmd_pop = (state == seq_idle) && !cmd_empty;

	// one beat per cycle when the request queue has room and a tag is free
	assign beat_issue = (state == seq_issue) && !req_full && tag_room;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= seq_idle;
			beats_left <= '0;
		end else begin
			case (state)
				seq_idle: begin
					if (cmd_pop) begin
						cur_addr   <= cmd_dout[CMD_W-1 -: $bits(addr_t)];
						beats_left <= cmd_dout[$bits(beats_t)-1:0];
						state      <= seq_issue;
					end
				end
				seq_issue: begin
					if (beat_issue) begin
						cur_addr   <= cur_addr + addr_t'(beat_bytes);
						beats_left <= beats_left - 1'b1;
						if (beats_left == beats_t'(1))
							state <= seq_idle; // last beat queued
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	// registered so it stays low through reset and drops on the accept edge
	always_ff @(posedge clk) begin
		if (rst)
			rd_ready <= 1'b0;
		else
			rd_ready <= cmd_empty && req_empty && (state == seq_idle)
				&& merge_idle && !rd_req;
	end

endmodule

`default_nettype wire

// File: hdl/read_merge.sv
/* buffers in-order read responses and pushes them into the input buffer;
   assumes responses never outnumber the beats issued */
`timescale 1ns/100ps
`default_nettype none

module read_merge import dnn_mem_pkg::*; #(
	parameter int LOG_DEPTH = 4
) (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  beat_issue,     // a beat request was queued
	input  wire logic  mem_resp_valid,
	input  wire data_t mem_resp_data,
	input  wire logic  inbuf_full,
	output logic       mem_resp_grant,
	output logic       inbuf_push,
	output data_t      inbuf_data,
	output logic       tag_room,
	output logic       merge_idle
);

	localparam int DEPTH = 1 << LOG_DEPTH;

	logic               resp_full;
	logic               resp_empty;
	logic [LOG_DEPTH:0] outstanding; // beats issued but not yet pushed

	sync_fifo #(.WIDTH($bits(data_t)), .LOG_DEPTH(LOG_DEPTH)) resp_q (
		.clk   (clk),
		.rst   (rst),
		.push  (mem_resp_grant),
		.din   (mem_resp_data),
		.pop   (inbuf_push),
		.dout  (inbuf_data),
		.full  (resp_full),
		.empty (resp_empty)
	);

	// accept in the same cycle while there is space
	assign mem_resp_grant = mem_resp_valid && !resp_full;

	// head goes to the input buffer when a beat is owed and there is room
	assign inbuf_push = !resp_empty && (outstanding != '0) && !inbuf_full;

	// outstanding is capped at DEPTH, so the response queue cannot overflow
	assign tag_room   = (outstanding < (LOG_DEPTH+1)'(DEPTH));
	assign merge_idle = (outstanding == '0) && resp_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= '0;
		end else begin
			case ({beat_issue, inbuf_push})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding; // issue and push cancel out
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/dnn_mem_bridge.sv
/* read-only bridge from accelerator commands to a single-beat memory port;
   wait for rd_ready before each command, zero-beat commands are illegal */
`timescale 1ns/100ps
`default_nettype none

module dnn_mem_bridge import dnn_mem_pkg::*; #(
	parameter int LOG_DEPTH = 4 // depth of every queue is 2**LOG_DEPTH
) (
	input  wire logic   clk,
	input  wire logic   rst,

	// read command from the accelerator
	input  wire logic   rd_req,
	input  wire addr_t  rd_addr,
	input  wire beats_t rd_beats,
	output logic        rd_ready,

	// memory request port
	output logic        mem_req_valid,
	output addr_t       mem_req_addr,
	input  wire logic   mem_req_grant,

	// memory response port, in request order
	input  wire logic   mem_resp_valid,
	input  wire data_t  mem_resp_data,
	output logic        mem_resp_grant,

	// accelerator input buffer
	input  wire logic   inbuf_full,
	output logic        inbuf_push,
	output data_t       inbuf_data
);

	logic beat_issue; // sequencer queued a beat
	logic tag_room;   // merge can count another beat
	logic merge_idle; // merge has drained

	read_sequencer #(.LOG_DEPTH(LOG_DEPTH)) u_seq (
		.clk           (clk),
		.rst           (rst),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_beats      (rd_beats),
		.mem_req_grant (mem_req_grant),
		.tag_room      (tag_room),
		.merge_idle    (merge_idle),
		.rd_ready      (rd_ready),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.beat_issue    (beat_issue)
	);

	read_merge #(.LOG_DEPTH(LOG_DEPTH)) u_merge (
		.clk            (clk),
		.rst            (rst),
		.beat_issue     (beat_issue),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data),
		.inbuf_full     (inbuf_full),
		.mem_resp_grant (mem_resp_grant),
		.inbuf_push     (inbuf_push),
		.inbuf_data     (inbuf_data),
		.tag_room       (tag_room),
		.merge_idle     (merge_idle)
	);

endmodule

`default_nettype wire

// File: testbench/dnn_mem_bridge_asserts.sv
/* protocol rules on the bridge ports, bound into dnn_mem_bridge;
   fail_count holds the number of failed properties */
`timescale 1ns/100ps
`default_nettype none

module dnn_mem_bridge_asserts import dnn_mem_pkg::*; (
	input wire logic   clk,
	input wire logic   rst,
	input wire logic   rd_req,
	input wire beats_t rd_beats,
	input wire logic   rd_ready,
	input wire logic   mem_req_valid,
	input wire addr_t  mem_req_addr,
	input wire logic   mem_req_grant,
	input wire logic   inbuf_full,
	input wire logic   inbuf_push
);

	int fail_count = 0;

	// commands only while the bridge is ready, so the queue never drops one
	a_req_when_ready: assert property (@(posedge clk) disable iff (rst)
		rd_req |-> rd_ready)
		else begin fail_count++; $error("rd_req while rd_ready is low"); end

	a_beats_nonzero: assert property (@(posedge clk) disable iff (rst)
		rd_req |-> (rd_beats != '0)) // zero-beat command is illegal
		else begin fail_count++; $error("rd_req with zero beats"); end

	// request holds until granted
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_grant |=> mem_req_valid && $stable(mem_req_addr))
		else begin fail_count++; $error("memory request changed before grant"); end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		inbuf_full |-> !inbuf_push)
		else begin fail_count++; $error("inbuf_push while inbuf_full"); end

endmodule

bind dnn_mem_bridge dnn_mem_bridge_asserts u_asserts (
	.clk           (clk),
	.rst           (rst),
	.rd_req        (rd_req),
	.rd_beats      (rd_beats),
	.rd_ready      (rd_ready),
	.mem_req_valid (mem_req_valid),
	.mem_req_addr  (mem_req_addr),
	.mem_req_grant (mem_req_grant),
	.inbuf_full    (inbuf_full),
	.inbuf_push    (inbuf_push)
);

`default_nettype wire

// File: testbench/tb_dnn_mem_bridge.sv
/* reads commands and stall rates from testbench/dnn_mem_testdata.txt, run from the project root;
   one command at a time, each sent only once rd_ready is high */
`timescale 1ns/100ps
`default_nettype none

module tb_dnn_mem_bridge import dnn_mem_pkg::*; ();

	localparam int max_wait = 5000; // cycles allowed for any single wait

	logic  clk;
	logic  rst;
	logic  rd_req;
	addr_t rd_addr;
	beats_t rd_beats;
	logic  rd_ready;
	logic  mem_req_valid;
	addr_t mem_req_addr;
	logic  mem_req_grant;
	logic  mem_resp_valid;
	data_t mem_resp_data;
	logic  mem_resp_grant;
	logic  inbuf_full;
	logic  inbuf_push;
	data_t inbuf_data;

	addr_t exp_addr[$];  // request addresses still to be granted
	data_t exp_data[$];  // words still to reach the input buffer
	addr_t pend_addr[$]; // granted requests awaiting a response
	int    pend_due[$];  // cycle from which each response may be offered
	int    cycle_count;
	int    push_count;
	int    total_beats;
	int    grant_stall;  // percent of cycles with grant low
	int    full_stall;   // percent of cycles with inbuf_full high

	dnn_mem_bridge #(.LOG_DEPTH(4)) dut (
		.clk            (clk),
		.rst            (rst),
		.rd_req         (rd_req),
		.rd_addr        (rd_addr),
		.rd_beats       (rd_beats),
		.rd_ready       (rd_ready),
		.mem_req_valid  (mem_req_valid),
		.mem_req_addr   (mem_req_addr),
		.mem_req_grant  (mem_req_grant),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data),
		.mem_resp_grant (mem_resp_grant),
		.inbuf_full     (inbuf_full),
		.inbuf_push     (inbuf_push),
		.inbuf_data     (inbuf_data)
	);

	always #2 clk = ~clk; // 4 ns period

	// memory word holds the address above and its inverse below
	function automatic data_t model_data(input addr_t a);
		return {a, ~a};
	endfunction

	task automatic stop_failed();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
			stop_failed();
		end
	endtask

	task automatic wait_ready(input string what);
		int n;
		n = 0;
		while (rd_ready !== 1'b1) begin
			@(posedge clk);
			#0.5;
			n++;
			if (n > max_wait) begin
				$display("timed out after %0d cycles waiting for rd_ready %s", max_wait, what);
				stop_failed();
			end
		end
	endtask

	// one-cycle command strobe plus the expected beats it should produce
	task automatic send_command(input addr_t a, input beats_t n);
		addr_t beat_addr;
		rd_addr  = a;
		rd_beats = n;
		rd_req   = 1'b1;
		for (int i = 0; i < int'(n); i++) begin
			beat_addr = a + addr_t'(i * 8); // 8-byte stride that wraps at 4 GiB
			exp_addr.push_back(beat_addr);
			exp_data.push_back(model_data(beat_addr));
		end
		total_beats += int'(n);
		@(posedge clk);
		#0.5;
		rd_req = 1'b0;
		check_value(rd_ready, 1'b0, "rd_ready after command accept");
	endtask

	// any failed protocol property ends the run
	always @(dut.u_asserts.fail_count) begin
		if (dut.u_asserts.fail_count != 0) begin
			$display("protocol assertion failed at %0t", $time);
			stop_failed();
		end
	end

	// memory model and scoreboard sample on the edge and drive 0.5 ns later
	always @(posedge clk) begin
		cycle_count++;
		if (rst) begin
			pend_addr.delete();
			pend_due.delete();
		end else begin
			if (mem_req_valid && mem_req_grant) begin
				if (exp_addr.size() == 0) begin
					$display("memory request at %0t with no beat expected", $time);
					stop_failed();
				end
				check_value(mem_req_addr, exp_addr.pop_front(), "request address");
				pend_addr.push_back(mem_req_addr);
				pend_due.push_back(cycle_count + int'($urandom_range(6, 1)));
			end
			if (mem_resp_valid && mem_resp_grant) begin
				void'(pend_addr.pop_front()); // response taken
				void'(pend_due.pop_front());
			end
			if (inbuf_push) begin
				check_value(inbuf_full, 1'b0, "push while input buffer full");
				if (exp_data.size() == 0) begin
					$display("input buffer push at %0t with no word expected", $time);
					stop_failed();
				end
				check_value(inbuf_data, exp_data.pop_front(), "input buffer data");
				push_count++;
			end
		end
		#0.5;
		mem_req_grant = ($urandom_range(99) >= grant_stall);
		inbuf_full    = ($urandom_range(99) < full_stall);
		// head response stays offered until granted so order is kept
		if (pend_addr.size() != 0 && pend_due[0] <= cycle_count) begin
			mem_resp_valid = 1'b1;
			mem_resp_data  = model_data(pend_addr[0]);
		end else begin
			mem_resp_valid = 1'b0;
		end
	end

	initial begin
		int    fd;
		int    code;
		string line;
		addr_t a;
		int    n;
		int    gs;
		int    fs;
		clk = 1'b0;
		rst = 1'b1;
		rd_req = 1'b0;
		rd_addr = '0;
		rd_beats = '0;
		mem_req_grant = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		inbuf_full = 1'b0;
		cycle_count = 0;
		push_count = 0;
		total_beats = 0;
		grant_stall = 0;
		full_stall = 0;
		void'($urandom(32'hc471d265));
		fd = $fopen("testbench/dnn_mem_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/dnn_mem_testdata.txt");
			stop_failed();
		end
		repeat (5) @(posedge clk);
		#0.5;
		rst = 1'b0;
		check_value(rd_ready, 1'b0, "rd_ready during reset");
		wait_ready("after reset");
		check_value(mem_req_valid, 1'b0, "mem_req_valid after reset");
		check_value(mem_resp_grant, 1'b0, "mem_resp_grant after reset");
		check_value(inbuf_push, 1'b0, "inbuf_push after reset");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0)
				continue;
			if (line.len() < 2 || line[0] == "#")
				continue; // blank or comment
			code = $sscanf(line, "%h %d %d %d", a, n, gs, fs);
			if (code != 4) begin
				$display("malformed test data line: %s", line);
				stop_failed();
			end
			grant_stall = gs;
			full_stall  = fs;
			wait_ready("before command");
			send_command(a, beats_t'(n));
			wait_ready("while draining");
			check_value(push_count, total_beats, "pushes when rd_ready returns");
		end
		$fclose(fd);
		check_value(exp_addr.size(), 0, "requests never granted");
		check_value(pend_addr.size(), 0, "responses never taken");
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/dnn_mem_testdata.txt
# columns: start address (hex), beat count (decimal, non-zero),
# grant stall percent, inbuf_full stall percent
00001000 1 0 0
00001000 4 0 0
00002000 16 0 0
00003000 17 0 0
00004000 40 0 0
00005008 8 50 0
00006000 12 0 50
00007000 20 30 30
00008000 33 70 0
00009000 33 0 70
0000a000 5 90 10
0000b000 24 10 90
fffffff0 4 20 20
00000000 2 0 0
0000c000 64 40 40
0000d018 3 60 60
0000e000 18 25 75
0000f000 9 75 25
00010000 100 20 20
00011000 1 95 95
00012000 7 50 50

// File: dnn_mem_bridge.f
hdl/dnn_mem_pkg.sv
hdl/sync_fifo.sv
hdl/read_sequencer.sv
hdl/read_merge.sv
hdl/dnn_mem_bridge.sv
testbench/dnn_mem_bridge_asserts.sv
testbench/tb_dnn_mem_bridge.sv

// File: Bender.yml
package:
  name: dnn_mem_bridge

sources:
  # RTL in compile order
  - files:
      - hdl/dnn_mem_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/read_sequencer.sv
      - hdl/read_merge.sv
      - hdl/dnn_mem_bridge.sv

  # testbench and bound assertions
  - target: test
    files:
      - testbench/dnn_mem_bridge_asserts.sv
      - testbench/tb_dnn_mem_bridge.sv
